// File: calc_pkg.sv
// Number format, operator codes, controller states and unit latencies for the calculator
package calc_pkg;

    // magnitude width of every number, sign bit is extra
    localparam int MAG_W = 15;

    // weight of one keypad digit when shifting the running magnitude
    localparam int DIGIT_BASE = 10;

    // start-to-finish cycles of the arithmetic units
    localparam int ADDSUB_LAT = 2;
    localparam int MULT_LAT = 16;

    // sign-magnitude word, sign set means negative
    typedef struct packed {
        logic sign;
        logic [MAG_W-1:0] mag;
    } sm_num_t;

    // keypad operator codes, OP_NEG toggles the sign of the entry
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG = 3'd1,
        OP_ADD = 3'd2,
        OP_SUB = 3'd3,
        OP_MUL = 3'd4
    } op_code_t;

    // controller states
    // entry of each operand goes wait key -> shift by ten -> add digit
    typedef enum logic [3:0] {
        KEY1_WAIT = 4'd0,
        MUL1_WAIT = 4'd1,
        ACC1 = 4'd2,
        KEY2_WAIT = 4'd3,
        MUL2_WAIT = 4'd4,
        ACC2 = 4'd5,
        DISPATCH = 4'd6,
        CALC_WAIT = 4'd7,
        SHOW = 4'd8
    } ctrl_state_t;

endpackage

// File: sm_addsub.sv
// Two-stage sign-magnitude adder/subtractor with start and finish strobes
`timescale 1ns/1ps

module sm_addsub (
    input logic clk,
    input logic nRST,
    input calc_pkg::sm_num_t in1,
    input calc_pkg::sm_num_t in2,
    input logic sub,
    input logic start,
    output calc_pkg::sm_num_t out,
    output logic finish
);

    typedef logic [$clog2(calc_pkg::ADDSUB_LAT + 1)-1:0] cnt_t;

    calc_pkg::sm_num_t a_q;
    calc_pkg::sm_num_t b_q;
    calc_pkg::sm_num_t res;
    cnt_t cnt;

    // delay counter, nonzero while an operation is in flight
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            cnt <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                cnt <= cnt_t'(calc_pkg::ADDSUB_LAT - 1);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == cnt_t'(1)) begin
                    finish <= 1'b1;
                end
            end
        end
    end

    // stage 2: compare magnitudes, then add or subtract
    always_comb begin
        res = a_q;
        if (a_q.sign == b_q.sign) begin
            res.mag = a_q.mag + b_q.mag;
            res.sign = a_q.sign;
        end else if (a_q.mag >= b_q.mag) begin
            res.mag = a_q.mag - b_q.mag;
            res.sign = a_q.sign;
        end else begin
            res.mag = b_q.mag - a_q.mag;
            res.sign = b_q.sign;
        end
        // no negative zero
        if (res.mag == '0) begin
            res.sign = 1'b0;
        end
    end

    // stage 1 operand capture, subtraction folds into the second sign
    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= in1;
            b_q.sign <= in2.sign ^ sub;
            b_q.mag <= in2.mag;
        end
        if (cnt == cnt_t'(1)) begin
            out <= res;
        end
    end

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!nRST) start |-> (cnt == '0)
    );

endmodule

// File: seq_multiply.sv
// Shift-and-add sign-magnitude multiplier, low magnitude bits kept, with start/finish strobes
`timescale 1ns/1ps

module seq_multiply (
    input logic clk,
    input logic nRST,
    input calc_pkg::sm_num_t in1,
    input calc_pkg::sm_num_t in2,
    input logic start,
    output calc_pkg::sm_num_t out,
    output logic finish
);

    typedef logic [$clog2(calc_pkg::MULT_LAT + 1)-1:0] cnt_t;

    logic [calc_pkg::MAG_W-1:0] acc;
    logic [calc_pkg::MAG_W-1:0] mcand;
    logic [calc_pkg::MAG_W-1:0] mplier;
    logic sign_q;
    cnt_t cnt;

    // cycle counter
    // load covers bit 0, the middle counts cover the remaining bits,
    // count 1 is the sign normalize cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            cnt <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                cnt <= cnt_t'(calc_pkg::MULT_LAT - 1);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == cnt_t'(1)) begin
                    finish <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            // first partial product folded into the load
            acc <= in2.mag[0] ? in1.mag : '0;
            mcand <= in1.mag << 1;
            mplier <= in2.mag >> 1;
            sign_q <= in1.sign ^ in2.sign;
        end else if (cnt > cnt_t'(1)) begin
            // bits shifted past the top are dropped, product wraps mod 2^MAG_W
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end else if (cnt == cnt_t'(1)) begin
            out.mag <= acc;
            // zero product is always positive
            out.sign <= sign_q & (acc != '0);
        end
    end

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!nRST) start |-> (cnt == '0)
    );

    a_finish_pulse: assert property (
        @(posedge clk) disable iff (!nRST) finish |=> !finish
    );

endmodule

// File: gencon.sv
// Keypad calculator controller: operand entry FSM, unit dispatch and display register
`timescale 1ns/1ps

module gencon (
    input logic clk,
    input logic nRST,
    input logic [3:0] keypad_input,
    input logic read_input,
    input calc_pkg::op_code_t operator_input,
    input logic equal_input,
    output logic complete,
    output calc_pkg::sm_num_t display_output
);

    typedef logic [calc_pkg::MAG_W-1:0] mag_t;

    calc_pkg::ctrl_state_t state;
    calc_pkg::ctrl_state_t next_state;

    // operands under entry and latched operator
    calc_pkg::sm_num_t op1;
    calc_pkg::sm_num_t op2;
    calc_pkg::op_code_t op_q;
    logic [3:0] digit_q;
    mag_t digit_ext;
    mag_t entry_mag;

    // unit side
    logic start_add;
    logic start_mult;
    logic add_finish;
    logic mult_finish;
    calc_pkg::sm_num_t add_out;
    calc_pkg::sm_num_t mult_out;
    calc_pkg::sm_num_t mult_in1;
    calc_pkg::sm_num_t mult_in2;

    // set when the multiplier owns the current calculation
    logic use_mul;
    logic calc_finish;
    calc_pkg::sm_num_t calc_out;
    calc_pkg::sm_num_t result_q;

    logic key_press;
    logic neg_press;
    logic op_valid;

    sm_addsub add_calc (
        .clk(clk),
        .nRST(nRST),
        .in1(op1),
        .in2(op2),
        .sub(op_q == calc_pkg::OP_SUB),
        .start(start_add),
        .out(add_out),
        .finish(add_finish)
    );

    seq_multiply mult_calc (
        .clk(clk),
        .nRST(nRST),
        .in1(mult_in1),
        .in2(mult_in2),
        .start(start_mult),
        .out(mult_out),
        .finish(mult_finish)
    );

    assign key_press = read_input
        && (state == calc_pkg::KEY1_WAIT || state == calc_pkg::KEY2_WAIT);
    assign neg_press = (operator_input == calc_pkg::OP_NEG);
    assign op_valid = operator_input inside {calc_pkg::OP_ADD, calc_pkg::OP_SUB,
        calc_pkg::OP_MUL};

    assign digit_ext = {{(calc_pkg::MAG_W - 4){1'b0}}, digit_q};
    assign entry_mag = (state == calc_pkg::MUL2_WAIT) ? op2.mag : op1.mag;

    // multiplier sharing
    // digit shift works on the bare magnitude so a sign toggled on zero survives
    always_comb begin
        if (state == calc_pkg::CALC_WAIT) begin
            mult_in1 = op1;
            mult_in2 = op2;
        end else begin
            mult_in1.sign = 1'b0;
            mult_in1.mag = entry_mag;
            mult_in2.sign = 1'b0;
            mult_in2.mag = mag_t'(calc_pkg::DIGIT_BASE);
        end
    end

    assign calc_finish = use_mul ? mult_finish : add_finish;
    assign calc_out = use_mul ? mult_out : add_out;

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::KEY1_WAIT: begin
                if (read_input) begin
                    next_state = calc_pkg::MUL1_WAIT;
                end
            end
            calc_pkg::MUL1_WAIT: begin
                if (mult_finish) begin
                    next_state = calc_pkg::ACC1;
                end
            end
            calc_pkg::ACC1: begin
                next_state = op_valid ? calc_pkg::KEY2_WAIT : calc_pkg::KEY1_WAIT;
            end
            calc_pkg::KEY2_WAIT: begin
                if (read_input) begin
                    next_state = calc_pkg::MUL2_WAIT;
                end
            end
            calc_pkg::MUL2_WAIT: begin
                if (mult_finish) begin
                    next_state = calc_pkg::ACC2;
                end
            end
            calc_pkg::ACC2: begin
                next_state = equal_input ? calc_pkg::DISPATCH : calc_pkg::KEY2_WAIT;
            end
            calc_pkg::DISPATCH: next_state = calc_pkg::CALC_WAIT;
            calc_pkg::CALC_WAIT: begin
                if (calc_finish) begin
                    next_state = calc_pkg::SHOW;
                end
            end
            calc_pkg::SHOW: next_state = calc_pkg::KEY1_WAIT;
            default: next_state = calc_pkg::KEY1_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= calc_pkg::KEY1_WAIT;
            op1 <= '0;
            op2 <= '0;
            op_q <= calc_pkg::OP_NONE;
            use_mul <= 1'b0;
            start_add <= 1'b0;
            start_mult <= 1'b0;
            complete <= 1'b0;
            display_output <= '0;
        end else begin
            state <= next_state;
            // start strobes land one edge after the key or dispatch
            start_mult <= key_press
                || (state == calc_pkg::DISPATCH && op_q == calc_pkg::OP_MUL);
            start_add <= (state == calc_pkg::DISPATCH && op_q != calc_pkg::OP_MUL);
            complete <= (state == calc_pkg::SHOW);

            case (state)
                calc_pkg::KEY1_WAIT: begin
                    if (neg_press) begin
                        op1.sign <= ~op1.sign;
                    end
                end
                calc_pkg::MUL1_WAIT: begin
                    if (mult_finish) begin
                        op1.mag <= mult_out.mag;
                    end
                end
                calc_pkg::ACC1: begin
                    op1.mag <= op1.mag + digit_ext;
                    if (op_valid) begin
                        op_q <= operator_input;
                    end
                end
                calc_pkg::KEY2_WAIT: begin
                    if (neg_press) begin
                        op2.sign <= ~op2.sign;
                    end
                end
                calc_pkg::MUL2_WAIT: begin
                    if (mult_finish) begin
                        op2.mag <= mult_out.mag;
                    end
                end
                calc_pkg::ACC2: op2.mag <= op2.mag + digit_ext;
                calc_pkg::DISPATCH: use_mul <= (op_q == calc_pkg::OP_MUL);
                calc_pkg::SHOW: begin
                    display_output <= result_q;
                    // ready for the next calculation
                    op1 <= '0;
                    op2 <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    // pressed digit and captured unit result
    always_ff @(posedge clk) begin
        if (key_press) begin
            digit_q <= keypad_input;
        end
        if (state == calc_pkg::CALC_WAIT && calc_finish) begin
            result_q <= calc_out;
        end
    end

    a_start_exclusive: assert property (
        @(posedge clk) disable iff (!nRST) !(start_add && start_mult)
    );

    a_complete_pulse: assert property (
        @(posedge clk) disable iff (!nRST) complete |=> !complete
    );

    a_state_legal: assert property (
        @(posedge clk) disable iff (!nRST)
        state inside {calc_pkg::KEY1_WAIT, calc_pkg::MUL1_WAIT, calc_pkg::ACC1,
            calc_pkg::KEY2_WAIT, calc_pkg::MUL2_WAIT, calc_pkg::ACC2,
            calc_pkg::DISPATCH, calc_pkg::CALC_WAIT, calc_pkg::SHOW}
    );

endmodule

// File: tb_gencon.sv
// Testbench for gencon with clock, reset, keypad entry tasks, reference model and checking assertions
`timescale 1ns/1ps

module tb_gencon;

    logic clk;
    logic nRST;
    logic [3:0] keypad_input;
    logic read_input;
    calc_pkg::op_code_t operator_input;
    logic equal_input;
    logic complete;
    calc_pkg::sm_num_t display_output;

    calc_pkg::sm_num_t expected;
    string test_name;
    int n_equal;
    int n_complete;

    gencon i_dut (
        .clk(clk),
        .nRST(nRST),
        .keypad_input(keypad_input),
        .read_input(read_input),
        .operator_input(operator_input),
        .equal_input(equal_input),
        .complete(complete),
        .display_output(display_output)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (nRST && complete) begin
            n_complete <= n_complete + 1;
        end
    end

    // operand as the keypad builds it with wrap at every digit
    function automatic calc_pkg::sm_num_t operand_value(input int negs,
        input logic [19:0] digits, input int nd);
        calc_pkg::sm_num_t v;
        int m;
        m = 0;
        for (int k = nd - 1; k >= 0; k--) begin
            m = (m * 10 + int'(digits[4*k +: 4])) % (1 << calc_pkg::MAG_W);
        end
        v.sign = negs[0];
        v.mag = 15'(m);
        return v;
    endfunction

    // sign-magnitude arithmetic rules with zero always positive
    function automatic calc_pkg::sm_num_t expected_result(input calc_pkg::sm_num_t a,
        input calc_pkg::sm_num_t b, input calc_pkg::op_code_t op);
        calc_pkg::sm_num_t r;
        logic b_sign;
        longint prod;
        int va;
        int vb;
        int sum;
        b_sign = b.sign ^ (op == calc_pkg::OP_SUB);
        if (op == calc_pkg::OP_MUL) begin
            prod = longint'(a.mag) * longint'(b.mag);
            r.mag = 15'(prod % 32768);
            r.sign = a.sign ^ b.sign;
        end else if (a.sign == b_sign) begin
            r.mag = 15'((int'(a.mag) + int'(b.mag)) % 32768);
            r.sign = a.sign;
        end else begin
            // differing signs never leave the magnitude range
            va = a.sign ? -int'(a.mag) : int'(a.mag);
            vb = b_sign ? -int'(b.mag) : int'(b.mag);
            sum = va + vb;
            r.sign = (sum < 0);
            r.mag = 15'((sum < 0) ? -sum : sum);
        end
        if (r.mag == '0) begin
            r.sign = 1'b0;
        end
        return r;
    endfunction

    task automatic press_key(input logic [3:0] d);
        keypad_input = d;
        read_input = 1'b1;
        @(negedge clk);
        read_input = 1'b0;
    endtask

    task automatic pulse_negate();
        operator_input = calc_pkg::OP_NEG;
        @(negedge clk);
        operator_input = calc_pkg::OP_NONE;
        @(negedge clk);
    endtask

    task automatic hold_levels(input calc_pkg::op_code_t op, input logic eq);
        operator_input = op;
        equal_input = eq;
        if (eq) begin
            n_equal++;
        end
    endtask

    // digit shift on the shared multiplier
    task automatic wait_entry_step();
        logic found;
        found = 1'b0;
        for (int i = 0; i < 40 && !found; i++) begin
            @(negedge clk);
            found = i_dut.mult_finish;
        end
        if (!found) begin
            $display("timeout: multiplier never finished a digit shift in %s", test_name);
            $display("TB FAILED");
            $fatal(1, "digit entry timeout");
        end
    endtask

    task automatic wait_complete();
        logic found;
        found = 1'b0;
        for (int i = 0; i < 60 && !found; i++) begin
            @(negedge clk);
            found = complete;
        end
        if (!found) begin
            $display("timeout: no complete pulse after equal in %s", test_name);
            $display("TB FAILED");
            $fatal(1, "calculation timeout");
        end else begin
            // pulse is sampled at the next rising edge with this test's expected value
            @(negedge clk);
        end
    endtask

    task automatic enter_operand(input int negs, input logic [19:0] digits, input int nd,
        input calc_pkg::op_code_t end_op, input logic end_eq);
        for (int n = 0; n < negs; n++) begin
            pulse_negate();
        end
        for (int k = nd - 1; k >= 0; k--) begin
            press_key(digits[4*k +: 4]);
            wait_entry_step();
            // last digit carries the operator or equal into ACC
            if (k == 0) begin
                hold_levels(end_op, end_eq);
            end
            @(negedge clk);
            @(negedge clk);
            if (k == 0) begin
                hold_levels(calc_pkg::OP_NONE, 1'b0);
            end
        end
    endtask

    task automatic run_calculation(input string name, input int negs1,
        input logic [19:0] d1, input int n1, input calc_pkg::op_code_t op,
        input int negs2, input logic [19:0] d2, input int n2);
        test_name = name;
        expected = expected_result(operand_value(negs1, d1, n1),
            operand_value(negs2, d2, n2), op);
        enter_operand(negs1, d1, n1, op, 1'b0);
        enter_operand(negs2, d2, n2, calc_pkg::OP_NONE, 1'b1);
        wait_complete();
    endtask

    a_result_match: assert property (
        @(posedge clk) disable iff (!nRST) complete |-> (display_output == expected)
    ) else begin
        $display("Error: %s expected %s%0d actual %s%0d", test_name,
            expected.sign ? "-" : "+", expected.mag,
            display_output.sign ? "-" : "+", display_output.mag);
        $display("TB FAILED");
        $fatal(1, "result mismatch");
    end

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (!nRST)
        (n_complete == 0 && !complete) |-> (display_output == '0)
    ) else begin
        $display("display is not zero before the first result");
        $display("TB FAILED");
        $fatal(1, "display not cleared");
    end

    // also catches complete before any equal
    a_one_complete: assert property (
        @(posedge clk) disable iff (!nRST) complete |-> (n_equal == n_complete + 1)
    ) else begin
        $display("complete pulsed without a matching equal in %s", test_name);
        $display("TB FAILED");
        $fatal(1, "extra complete");
    end

    a_display_hold: assert property (
        @(posedge clk) disable iff (!nRST)
        (display_output != $past(display_output)) |-> complete
    ) else begin
        $display("display changed without a complete pulse in %s", test_name);
        $display("TB FAILED");
        $fatal(1, "display not held");
    end

    initial begin
        logic [19:0] d1;
        logic [19:0] d2;
        int n1;
        int n2;
        calc_pkg::op_code_t op;
        clk = 1'b0;
        nRST = 1'b0;
        keypad_input = '0;
        read_input = 1'b0;
        operator_input = calc_pkg::OP_NONE;
        equal_input = 1'b0;
        expected = '0;
        test_name = "reset";
        n_equal = 0;
        n_complete = 0;
        void'($urandom(32'hdf8f_8109));
        repeat (8) @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);

        run_calculation("add_multi_digit", 0, 20'h123, 3, calc_pkg::OP_ADD, 0, 20'h45, 2);
        run_calculation("sub_cross_zero", 0, 20'h7, 1, calc_pkg::OP_SUB, 0, 20'h20, 2);
        run_calculation("sub_equal", 0, 20'h5, 1, calc_pkg::OP_SUB, 0, 20'h5, 1);
        run_calculation("neg_mul", 1, 20'h12, 2, calc_pkg::OP_MUL, 0, 20'h11, 2);
        run_calculation("neg_zero_mul", 1, 20'h0, 1, calc_pkg::OP_MUL, 0, 20'h9, 1);
        run_calculation("double_neg_add", 2, 20'h3, 1, calc_pkg::OP_ADD, 0, 20'h4, 1);
        run_calculation("neg_second_sub", 0, 20'h9, 1, calc_pkg::OP_SUB, 1, 20'h6, 1);
        run_calculation("wrap_entry", 0, 20'h40000, 5, calc_pkg::OP_ADD, 0, 20'h1, 1);
        run_calculation("wrap_product", 0, 20'h300, 3, calc_pkg::OP_MUL, 0, 20'h200, 3);

        for (int i = 0; i < 20; i++) begin
            n1 = int'($urandom_range(4, 2));
            n2 = int'($urandom_range(4, 2));
            d1 = '0;
            d2 = '0;
            for (int j = 0; j < n1; j++) begin
                d1 = {d1[15:0], 4'($urandom_range(9, 0))};
            end
            for (int j = 0; j < n2; j++) begin
                d2 = {d2[15:0], 4'($urandom_range(9, 0))};
            end
            case ($urandom_range(2, 0))
                0: op = calc_pkg::OP_ADD;
                1: op = calc_pkg::OP_SUB;
                default: op = calc_pkg::OP_MUL;
            endcase
            run_calculation($sformatf("random_%0d", i), int'($urandom_range(1, 0)), d1, n1,
                op, int'($urandom_range(1, 0)), d2, n2);
        end

        // idle stretch so a stray complete would still be seen
        repeat (20) @(negedge clk);
        if (n_complete != n_equal) begin
            $display("saw %0d complete pulses for %0d equal presses", n_complete, n_equal);
            $display("TB FAILED");
            $fatal(1, "completion count wrong");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
calc_pkg.sv
sm_addsub.sv
seq_multiply.sv
gencon.sv
tb_gencon.sv

// File: Bender.yml
package:
  name: gencon

sources:
  - calc_pkg.sv
  - sm_addsub.sv
  - seq_multiply.sv
  - gencon.sv
  - target: simulation
    files:
      - tb_gencon.sv
